//--- hdl/dbg_cpu_ctrl.sv
`timescale 1ns/1ps

module dbg_cpu_ctrl import dbg_pkg::*; (
  input  logic              dbg_clk,
  input  logic              dbg_rst,
  input  dbg_word_u         din,
  input  reg_wr_t           reg_wr,
  input  logic              dbg_halt_st,   // CPU halt status
  input  logic              dbg_en_s,
  input  logic              cpu_en_s,
  input  logic              puc_pnd_set,
  input  logic              decode_noirq,  // Opcode decode cycle
  input  logic [DBG_DW-1:0] fe_mdb_in,
  input  logic              mem_halt_req,  // From access FSM
  input  logic              mem_run_req,
  output logic [7:0]        cpu_ctl,
  output logic [7:0]        cpu_stat,
  output logic              dbg_halt_cmd,
  output logic              dbg_freeze,
  output logic              dbg_cpu_reset
);

  cpu_ctl_t  ctl_q;
  cpu_stat_t stat_v;
  logic      halt_cpu;
  logic      run_cpu;
  logic      istep;
  logic      dbg_swbrk;
  logic      halt_rst;
  logic      swbrk_pnd;
  logic      puc_pnd;
  logic      swbrk_clr;
  logic      puc_clr;
  logic [1:0] inc_step;
  logic      halt_flag;
  logic      halt_flag_set;
  logic      halt_flag_clr;

  // --------------------------------------------------------------------------
  // CPU_CTL
  // --------------------------------------------------------------------------
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      ctl_q <= CPU_CTL_RST;
    end else if (reg_wr.cpu_ctl) begin
      ctl_q <= din.cpu_ctl.f & CPU_CTL_HOLD;  // Command bits not stored
    end
  end

  assign cpu_ctl = ctl_q;

  // Commands only act when they change something
  assign halt_cpu = reg_wr.cpu_ctl & din.cpu_ctl.f.halt  & ~dbg_halt_st;
  assign run_cpu  = reg_wr.cpu_ctl & din.cpu_ctl.f.run   & dbg_halt_st;
  assign istep    = reg_wr.cpu_ctl & din.cpu_ctl.f.istep & dbg_halt_st;

  // --------------------------------------------------------------------------
  // CPU_STAT
  // --------------------------------------------------------------------------
  assign swbrk_clr = reg_wr.cpu_stat & din.cpu_stat.f.swbrk_pnd;
  assign puc_clr   = reg_wr.cpu_stat & din.cpu_stat.f.puc_pnd;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      swbrk_pnd <= 1'b0;
      puc_pnd   <= 1'b0;
    end else begin
      swbrk_pnd <= (swbrk_pnd & ~swbrk_clr) | dbg_swbrk;  // Set wins
      puc_pnd   <= (puc_pnd & ~puc_clr) | puc_pnd_set;
    end
  end

  always_comb begin
    stat_v           = '0;
    stat_v.swbrk_pnd = swbrk_pnd;
    stat_v.puc_pnd   = puc_pnd;
    stat_v.halt_run  = dbg_halt_st;  // Live status
  end

  assign cpu_stat = stat_v;

  // --------------------------------------------------------------------------
  // Break sources, freeze and reset
  // --------------------------------------------------------------------------
  assign dbg_swbrk     = (fe_mdb_in == DBG_SWBRK_OP) & decode_noirq & ctl_q.sw_brk_en;
  assign halt_rst      = ctl_q.rst_brk_en & dbg_en_s & puc_pnd_set;
  assign dbg_freeze    = dbg_halt_st & (ctl_q.frz_brk_en | ~cpu_en_s);
  assign dbg_cpu_reset = ctl_q.cpu_rst;

  // Step window opens halt for two cycles
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      inc_step <= 2'b00;
    end else if (istep) begin
      inc_step <= 2'b11;
    end else begin
      inc_step <= {inc_step[0], 1'b0};
    end
  end

  // --------------------------------------------------------------------------
  // Run / halt
  // --------------------------------------------------------------------------
  assign halt_flag_clr = run_cpu | mem_run_req;
  assign halt_flag_set = halt_cpu | halt_rst | dbg_swbrk | mem_halt_req;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      halt_flag <= 1'b0;
    end else if (halt_flag_clr) begin
      halt_flag <= 1'b0;
    end else if (halt_flag_set) begin
      halt_flag <= 1'b1;
    end
  end

  // Set and clear both show up in the request cycle
  assign dbg_halt_cmd = (halt_flag | halt_flag_set) & ~halt_flag_clr & ~inc_step[1];

endmodule

//--- hdl/dbg_mem_ctrl.sv
`timescale 1ns/1ps

module dbg_mem_ctrl import dbg_pkg::*; (
  input  logic              dbg_clk,
  input  logic              dbg_rst,
  input  dbg_word_u         din,
  input  reg_wr_t           reg_wr,
  input  logic              dbg_halt_st,
  input  logic [DBG_DW-1:0] dbg_mem_din,
  input  logic [DBG_DW-1:0] dbg_reg_din,
  output mem_bus_t          mem,
  output logic              dbg_reg_wr,
  output logic              mem_halt_req,  // One-cycle pulses
  output logic              mem_run_req,
  output logic [7:0]        mem_ctl,
  output logic [DBG_DW-1:0] mem_addr,
  output logic [DBG_DW-1:0] mem_data
);

  mem_ctl_t          ctl_q;
  logic              mem_start;
  mem_state_e        state;
  mem_state_e        state_nxt;
  logic              access;
  logic              reg_rd;
  logic              mem_rd;
  logic              mem_rd_dly;
  logic [1:0]        wr_msk;
  logic [DBG_DW-1:0] mem_din_bw;

  // --------------------------------------------------------------------------
  // MEM_CTL, MEM_ADDR, MEM_DATA
  // --------------------------------------------------------------------------
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      ctl_q     <= '0;
      mem_start <= 1'b0;
    end else begin
      if (reg_wr.mem_ctl) begin
        ctl_q <= din.mem_ctl.f & MEM_CTL_HOLD;
      end
      mem_start <= reg_wr.mem_ctl & din.mem_ctl.f.start;  // START is a pulse
    end
  end

  assign mem_ctl = ctl_q;

  // Byte reads come back zero-extended from the addressed lane
  assign mem_din_bw = !ctl_q.bw   ? dbg_mem_din :
                      mem_addr[0] ? {8'h00, dbg_mem_din[15:8]} :
                                    {8'h00, dbg_mem_din[7:0]};

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      mem_addr <= '0;
      mem_data <= '0;
    end else begin
      if (reg_wr.mem_addr) begin
        mem_addr <= din.raw;
      end
      if (reg_wr.mem_data) begin
        mem_data <= din.raw;
      end else if (reg_rd) begin
        mem_data <= dbg_reg_din;      // Register file answers at once
      end else if (mem_rd_dly) begin
        mem_data <= mem_din_bw;       // Memory one cycle later
      end
    end
  end

  // --------------------------------------------------------------------------
  // Access FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      M_IDLE: begin
        if (mem_start) begin
          state_nxt = dbg_halt_st ? M_ACCESS : M_SET_BRK;
        end
      end
      M_SET_BRK: begin
        if (dbg_halt_st) begin
          state_nxt = M_ACCESS_BRK;  // CPU stopped
        end
      end
      M_ACCESS_BRK: state_nxt = M_IDLE;
      M_ACCESS:     state_nxt = M_IDLE;
      default:      state_nxt = M_IDLE;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= M_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign mem_halt_req = (state == M_IDLE) & (state_nxt == M_SET_BRK);
  assign mem_run_req  = (state == M_ACCESS_BRK) & (state_nxt == M_IDLE);
  assign access       = (state == M_ACCESS) | (state == M_ACCESS_BRK);

  // --------------------------------------------------------------------------
  // CPU side
  // --------------------------------------------------------------------------
  assign dbg_reg_wr = access & ctl_q.rd_wr & ctl_q.mem_reg;
  assign reg_rd     = access & ~ctl_q.rd_wr & ctl_q.mem_reg;
  assign mem_rd     = mem.en & ~ctl_q.rd_wr;

  assign wr_msk = !ctl_q.bw ? 2'b11 : (mem_addr[0] ? 2'b10 : 2'b01);

  assign mem.addr = mem_addr;
  assign mem.en   = access & ~ctl_q.mem_reg;
  assign mem.wr   = {2{mem.en & ctl_q.rd_wr}} & wr_msk;
  assign mem.dout = !ctl_q.bw   ? mem_data :
                    mem_addr[0] ? {mem_data[7:0], 8'h00} :
                                  {8'h00, mem_data[7:0]};  // Low byte to lane

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      mem_rd_dly <= 1'b0;
    end else begin
      mem_rd_dly <= mem_rd;
    end
  end

endmodule

//--- hdl/dbg_pkg.sv
package dbg_pkg;

  // --------------------------------------------------------------------------
  // Widths and register map
  // --------------------------------------------------------------------------
  localparam int DBG_AW = 6;   // Debug register address
  localparam int DBG_DW = 16;  // Debug data word

  localparam logic [DBG_AW-1:0] REG_CPU_ID_LO = 6'h00;
  localparam logic [DBG_AW-1:0] REG_CPU_ID_HI = 6'h01;
  localparam logic [DBG_AW-1:0] REG_CPU_CTL   = 6'h02;
  localparam logic [DBG_AW-1:0] REG_CPU_STAT  = 6'h03;
  localparam logic [DBG_AW-1:0] REG_MEM_CTL   = 6'h04;
  localparam logic [DBG_AW-1:0] REG_MEM_ADDR  = 6'h05;
  localparam logic [DBG_AW-1:0] REG_MEM_DATA  = 6'h06;
  localparam logic [DBG_AW-1:0] REG_CPU_NR    = 6'h18;

  localparam logic [DBG_DW-1:0] DBG_SWBRK_OP = 16'h4343;  // Software break opcode

  // Stored bits and reset values of the control bytes
  localparam logic [7:0] CPU_CTL_HOLD = 8'h78;  // CPU_RST down to SW_BRK_EN
  localparam logic [7:0] CPU_CTL_RST  = 8'h10;  // FRZ_BRK_EN only
  localparam logic [7:0] MEM_CTL_HOLD = 8'h0E;  // B/W, MEM/REG, RD/WR

  // --------------------------------------------------------------------------
  // Register layouts
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic reserved;
    logic cpu_rst;     // Hold CPU in reset
    logic rst_brk_en;  // Halt after PUC
    logic frz_brk_en;  // Freeze peripherals on halt
    logic sw_brk_en;   // Software breakpoint enable
    logic istep;       // Command bits
    logic run;
    logic halt;
  } cpu_ctl_t;

  typedef struct packed {
    logic [3:0] reserved;
    logic       bw;       // 1 = byte access
    logic       mem_reg;  // 1 = CPU register
    logic       rd_wr;    // 1 = write
    logic       start;
  } mem_ctl_t;

  typedef struct packed {
    logic [3:0] hwbrk_pnd;  // No hardware units here
    logic       swbrk_pnd;
    logic       puc_pnd;
    logic       reserved;
    logic       halt_run;
  } cpu_stat_t;

  // One host data word, read through the view its address selects
  typedef union packed {
    logic [DBG_DW-1:0] raw;
    struct packed {
      logic [7:0] pad;
      cpu_ctl_t   f;
    } cpu_ctl;
    struct packed {
      logic [7:0] pad;
      mem_ctl_t   f;
    } mem_ctl;
    struct packed {
      logic [7:0] pad;
      cpu_stat_t  f;
    } cpu_stat;
  } dbg_word_u;

  // --------------------------------------------------------------------------
  // Inter-block bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic cpu_ctl;
    logic cpu_stat;
    logic mem_ctl;
    logic mem_addr;
    logic mem_data;
  } reg_wr_t;

  typedef struct packed {
    logic [DBG_AW-1:0] addr;
    dbg_word_u         din;
    logic              wr;  // One-cycle strobes
    logic              rd;
  } dbg_host_t;

  typedef struct packed {
    logic [7:0]        cpu_ctl;
    logic [7:0]        cpu_stat;
    logic [7:0]        mem_ctl;
    logic [DBG_DW-1:0] mem_addr;
    logic [DBG_DW-1:0] mem_data;
  } rd_view_t;

  typedef struct packed {
    logic [DBG_DW-1:0] addr;
    logic [DBG_DW-1:0] dout;
    logic              en;
    logic [1:0]        wr;  // Byte write enables
  } mem_bus_t;

  typedef enum logic [1:0] {
    M_IDLE,
    M_SET_BRK,     // Wait for CPU to halt
    M_ACCESS_BRK,  // Access then resume
    M_ACCESS
  } mem_state_e;

endpackage

//--- hdl/dbg_reg_access.sv
`timescale 1ns/1ps

module dbg_reg_access import dbg_pkg::*; (
  input  logic              dbg_clk,
  input  logic              dbg_rst,
  input  dbg_host_t         host,
  input  logic [31:0]       cpu_id,
  input  logic [15:0]       cpu_nr,
  input  rd_view_t          view,
  output reg_wr_t           reg_wr,
  output logic [DBG_DW-1:0] dbg_dout,
  output logic              rd_rdy
);

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  logic sel_id_lo;
  logic sel_id_hi;
  logic sel_cpu_ctl;
  logic sel_cpu_stat;
  logic sel_mem_ctl;
  logic sel_mem_addr;
  logic sel_mem_data;
  logic sel_cpu_nr;

  assign sel_id_lo    = (host.addr == REG_CPU_ID_LO);
  assign sel_id_hi    = (host.addr == REG_CPU_ID_HI);
  assign sel_cpu_ctl  = (host.addr == REG_CPU_CTL);
  assign sel_cpu_stat = (host.addr == REG_CPU_STAT);
  assign sel_mem_ctl  = (host.addr == REG_MEM_CTL);
  assign sel_mem_addr = (host.addr == REG_MEM_ADDR);
  assign sel_mem_data = (host.addr == REG_MEM_DATA);
  assign sel_cpu_nr   = (host.addr == REG_CPU_NR);

  // Write strobes for the writable registers
  assign reg_wr.cpu_ctl  = host.wr & sel_cpu_ctl;
  assign reg_wr.cpu_stat = host.wr & sel_cpu_stat;  // Pending clear
  assign reg_wr.mem_ctl  = host.wr & sel_mem_ctl;
  assign reg_wr.mem_addr = host.wr & sel_mem_addr;
  assign reg_wr.mem_data = host.wr & sel_mem_data;

  // --------------------------------------------------------------------------
  // Read data
  // --------------------------------------------------------------------------
  // Unknown addresses fall out of the AND-OR mux as zero
  assign dbg_dout = (cpu_id[15:0]           & {DBG_DW{sel_id_lo}})
                  | (cpu_id[31:16]          & {DBG_DW{sel_id_hi}})
                  | ({8'h00, view.cpu_ctl}  & {DBG_DW{sel_cpu_ctl}})
                  | ({8'h00, view.cpu_stat} & {DBG_DW{sel_cpu_stat}})
                  | ({8'h00, view.mem_ctl}  & {DBG_DW{sel_mem_ctl}})
                  | (view.mem_addr          & {DBG_DW{sel_mem_addr}})
                  | (view.mem_data          & {DBG_DW{sel_mem_data}})
                  | (cpu_nr                 & {DBG_DW{sel_cpu_nr}});

  // Data valid one cycle after the read pulse
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      rd_rdy <= 1'b0;
    end else begin
      rd_rdy <= host.rd;
    end
  end

endmodule

//--- hdl/dbg_unit.sv
`timescale 1ns/1ps

module dbg_unit import dbg_pkg::*; (
  input  logic              dbg_clk,
  input  logic              dbg_rst,
  input  dbg_host_t         host,          // Host register bus
  output logic [DBG_DW-1:0] dbg_dout,
  output logic              dbg_rd_rdy,
  input  logic [31:0]       cpu_id,
  input  logic [7:0]        cpu_nr_inst,
  input  logic [7:0]        cpu_nr_total,
  input  logic              dbg_halt_st,
  input  logic              dbg_en_s,
  input  logic              cpu_en_s,
  input  logic              puc_pnd_set,
  input  logic              decode_noirq,
  input  logic [DBG_DW-1:0] fe_mdb_in,
  input  logic [DBG_DW-1:0] dbg_mem_din,
  input  logic [DBG_DW-1:0] dbg_reg_din,
  output mem_bus_t          mem,
  output logic              dbg_reg_wr,
  output logic              dbg_halt_cmd,
  output logic              dbg_freeze,
  output logic              dbg_cpu_reset
);

  reg_wr_t  reg_wr;
  rd_view_t view;          // Register values for the read mux
  logic     mem_halt_req;
  logic     mem_run_req;

  dbg_reg_access u_reg_access (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .host     (host),
    .cpu_id   (cpu_id),
    .cpu_nr   ({cpu_nr_total, cpu_nr_inst}),
    .view     (view),
    .reg_wr   (reg_wr),
    .dbg_dout (dbg_dout),
    .rd_rdy   (dbg_rd_rdy)
  );

  dbg_cpu_ctrl u_cpu_ctrl (
    .dbg_clk       (dbg_clk),
    .dbg_rst       (dbg_rst),
    .din           (host.din),
    .reg_wr        (reg_wr),
    .dbg_halt_st   (dbg_halt_st),
    .dbg_en_s      (dbg_en_s),
    .cpu_en_s      (cpu_en_s),
    .puc_pnd_set   (puc_pnd_set),
    .decode_noirq  (decode_noirq),
    .fe_mdb_in     (fe_mdb_in),
    .mem_halt_req  (mem_halt_req),
    .mem_run_req   (mem_run_req),
    .cpu_ctl       (view.cpu_ctl),
    .cpu_stat      (view.cpu_stat),
    .dbg_halt_cmd  (dbg_halt_cmd),
    .dbg_freeze    (dbg_freeze),
    .dbg_cpu_reset (dbg_cpu_reset)
  );

  dbg_mem_ctrl u_mem_ctrl (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .din          (host.din),
    .reg_wr       (reg_wr),
    .dbg_halt_st  (dbg_halt_st),
    .dbg_mem_din  (dbg_mem_din),
    .dbg_reg_din  (dbg_reg_din),
    .mem          (mem),
    .dbg_reg_wr   (dbg_reg_wr),
    .mem_halt_req (mem_halt_req),
    .mem_run_req  (mem_run_req),
    .mem_ctl      (view.mem_ctl),
    .mem_addr     (view.mem_addr),
    .mem_data     (view.mem_data)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_dbg_unit -f src.f -o tb_dbg_unit
out=$(./obj_dir/tb_dbg_unit)
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- src.f
hdl/dbg_pkg.sv
hdl/dbg_reg_access.sv
hdl/dbg_cpu_ctrl.sv
hdl/dbg_mem_ctrl.sv
hdl/dbg_unit.sv
tb/dbg_cpu_model.sv
tb/tb_dbg_unit.sv

//--- tb/dbg_cpu_model.sv
`timescale 1ns/1ps

module dbg_cpu_model import dbg_pkg::*; (
  input  logic              dbg_clk,
  input  logic              dbg_rst,
  input  logic              dbg_halt_cmd,
  input  mem_bus_t          mem,          // Debug memory port
  input  logic              dbg_reg_wr,
  output logic              dbg_halt_st,
  output logic [DBG_DW-1:0] dbg_mem_din,  // One cycle after en
  output logic [DBG_DW-1:0] dbg_reg_din
);

  logic [DBG_DW-1:0] mem_arr [0:255];  // 256 words, byte addressed
  logic [DBG_DW-1:0] regs    [0:15];
  logic [7:0]        widx;

  assign widx        = mem.addr[8:1];  // Bit 0 picks the byte lane
  assign dbg_reg_din = regs[mem.addr[3:0]];

  // Fill patterns
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem_arr[i] = {8'(i), ~8'(i)};
    end
    for (int i = 0; i < 16; i++) begin
      regs[i] = 16'hA500 + 16'(i);
    end
  end

  // Halt status trails the command by one cycle
  always @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_halt_st <= 1'b0;
      dbg_mem_din <= '0;
    end else begin
      dbg_halt_st <= dbg_halt_cmd;
      if (mem.en && mem.wr == 2'b00) begin
        dbg_mem_din <= mem_arr[widx];  // Late read data
      end
    end
  end

  always @(posedge dbg_clk) begin
    if (mem.en && mem.wr[0]) mem_arr[widx][7:0]  <= mem.dout[7:0];
    if (mem.en && mem.wr[1]) mem_arr[widx][15:8] <= mem.dout[15:8];
    if (dbg_reg_wr) regs[mem.addr[3:0]] <= mem.dout;  // Register file write
  end

endmodule

//--- tb/tb_dbg_unit.sv
`timescale 1ns/1ps

module tb_dbg_unit import dbg_pkg::*; ();

  localparam logic [31:0] CPU_ID   = 32'h1234_5678;
  localparam logic [7:0]  NR_INST  = 8'h01;
  localparam logic [7:0]  NR_TOTAL = 8'h04;
  localparam int          LIMIT    = 50;  // Cycles per wait

  logic              dbg_clk;
  logic              dbg_rst;
  dbg_host_t         host;
  logic [DBG_DW-1:0] dbg_dout;
  logic              dbg_rd_rdy;
  logic [31:0]       cpu_id;
  logic [7:0]        cpu_nr_inst;
  logic [7:0]        cpu_nr_total;
  logic              dbg_halt_st;
  logic              dbg_en_s;
  logic              cpu_en_s;
  logic              puc_pnd_set;
  logic              decode_noirq;
  logic [DBG_DW-1:0] fe_mdb_in;
  logic [DBG_DW-1:0] dbg_mem_din;
  logic [DBG_DW-1:0] dbg_reg_din;
  mem_bus_t          mem;
  logic              dbg_reg_wr;
  logic              dbg_halt_cmd;
  logic              dbg_freeze;
  logic              dbg_cpu_reset;

  int                errors;
  int                tests_run;
  int                tests_failed;
  logic              cmd_at_wr;   // dbg_halt_cmd during the write cycle
  logic [DBG_DW-1:0] acc_dout;    // Bus seen at the access pulse
  logic [DBG_DW-1:0] acc_addr;
  logic [1:0]        acc_wr;
  logic              acc_reg_wr;

  dbg_unit u_dbg_unit (.*);

  dbg_cpu_model u_cpu_model (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .dbg_halt_cmd (dbg_halt_cmd),
    .mem          (mem),
    .dbg_reg_wr   (dbg_reg_wr),
    .dbg_halt_st  (dbg_halt_st),
    .dbg_mem_din  (dbg_mem_din),
    .dbg_reg_din  (dbg_reg_din)
  );

  always #20 dbg_clk = ~dbg_clk;  // 40 ns period

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task tick;
    @(posedge dbg_clk);
    #2;  // Drive point
  endtask

  task note_timeout(input string why);
    $display("timeout at %0t: %s", $time, why);
    errors++;
  endtask

  task expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task reg_write(input logic [DBG_AW-1:0] addr, input logic [15:0] data);
    host.addr     = addr;
    host.din.raw  = data;
    host.wr       = 1'b1;
    #1;
    cmd_at_wr     = dbg_halt_cmd;  // Same-cycle halt response
    tick;
    host.wr       = 1'b0;
  endtask

  // Read data is combinational and rd_rdy follows a cycle later
  task read_expect(input logic [DBG_AW-1:0] addr, input logic [15:0] exp, input string name);
    logic [15:0] data;
    host.addr = addr;
    host.rd   = 1'b1;
    #1;
    data      = dbg_dout;
    tick;
    host.rd   = 1'b0;
    expect_bit("dbg_rd_rdy", dbg_rd_rdy, 1'b1);
    tick;
    expect_bit("dbg_rd_rdy", dbg_rd_rdy, 1'b0);  // Single pulse
    expect_eq(name, data, exp);
  endtask

  task wait_halt_st(input logic val);
    int n;
    n = 0;
    while (dbg_halt_st !== val && n < LIMIT) begin
      n++;
      tick;
    end
    if (dbg_halt_st !== val) note_timeout("CPU halt status never reached the expected level");
  endtask

  task wait_access;
    int n;
    n = 0;
    while (!mem.en && !dbg_reg_wr && n < LIMIT) begin
      n++;
      tick;
    end
    if (!mem.en && !dbg_reg_wr) begin
      note_timeout("no memory or register access pulse");
    end else begin
      acc_dout   = mem.dout;
      acc_addr   = mem.addr;
      acc_wr     = mem.wr;
      acc_reg_wr = dbg_reg_wr;
    end
  endtask

  task report_test(input string name, input int e0);
    tests_run++;
    if (errors == e0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail, %0d errors", name, errors - e0);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task check_reset_state;
    int e0;
    e0 = errors;
    expect_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    expect_bit("dbg_cpu_reset", dbg_cpu_reset, 1'b0);
    expect_bit("dbg_freeze", dbg_freeze, 1'b0);
    expect_bit("mem.en", mem.en, 1'b0);
    expect_bit("mem.wr", |mem.wr, 1'b0);
    expect_bit("dbg_reg_wr", dbg_reg_wr, 1'b0);
    read_expect(REG_CPU_CTL, 16'h0010, "CPU_CTL");  // FRZ_BRK_EN only
    read_expect(REG_MEM_CTL, 16'h0000, "MEM_CTL");
    read_expect(REG_MEM_ADDR, 16'h0000, "MEM_ADDR");
    read_expect(REG_MEM_DATA, 16'h0000, "MEM_DATA");
    read_expect(REG_CPU_ID_LO, CPU_ID[15:0], "CPU_ID_LO");
    read_expect(REG_CPU_ID_HI, CPU_ID[31:16], "CPU_ID_HI");
    read_expect(REG_CPU_NR, {NR_TOTAL, NR_INST}, "CPU_NR");
    report_test("reset state", e0);
  endtask

  task halt_and_run;
    int e0;
    e0 = errors;
    reg_write(REG_CPU_CTL, 16'h0011);  // HALT
    expect_bit("dbg_halt_cmd", cmd_at_wr, 1'b1);
    wait_halt_st(1'b1);
    read_expect(REG_CPU_STAT, 16'h0001, "CPU_STAT");
    expect_bit("dbg_freeze", dbg_freeze, 1'b1);
    reg_write(REG_CPU_CTL, 16'h0012);  // RUN
    expect_bit("dbg_halt_cmd", cmd_at_wr, 1'b0);
    wait_halt_st(1'b0);
    read_expect(REG_CPU_STAT, 16'h0000, "CPU_STAT");
    reg_write(REG_CPU_CTL, 16'h0050);  // CPU_RST
    expect_bit("dbg_cpu_reset", dbg_cpu_reset, 1'b1);
    reg_write(REG_CPU_CTL, 16'h0010);
    expect_bit("dbg_cpu_reset", dbg_cpu_reset, 1'b0);
    report_test("halt and run", e0);
  endtask

  task break_sources;
    int e0;
    e0 = errors;
    reg_write(REG_CPU_CTL, 16'h0018);  // SW_BRK_EN
    fe_mdb_in    = 16'h4343;           // Break opcode fetched
    decode_noirq = 1'b1;
    tick;
    fe_mdb_in    = 16'h0000;
    decode_noirq = 1'b0;
    wait_halt_st(1'b1);
    read_expect(REG_CPU_STAT, 16'h0009, "CPU_STAT");
    reg_write(REG_CPU_STAT, 16'h0008);  // Write 1 to clear
    read_expect(REG_CPU_STAT, 16'h0001, "CPU_STAT");
    reg_write(REG_CPU_CTL, 16'h0012);
    wait_halt_st(1'b0);
    // Halt after reset
    reg_write(REG_CPU_CTL, 16'h0030);
    dbg_en_s    = 1'b1;
    puc_pnd_set = 1'b1;
    tick;
    puc_pnd_set = 1'b0;
    wait_halt_st(1'b1);
    read_expect(REG_CPU_STAT, 16'h0005, "CPU_STAT");
    reg_write(REG_CPU_STAT, 16'h0004);
    read_expect(REG_CPU_STAT, 16'h0001, "CPU_STAT");
    dbg_en_s = 1'b0;
    reg_write(REG_CPU_CTL, 16'h0010);  // Stays halted
    report_test("break sources", e0);
  endtask

  task single_step;
    int e0;
    int n;
    e0 = errors;
    n  = 0;
    wait_halt_st(1'b1);
    reg_write(REG_CPU_CTL, 16'h0014);  // ISTEP
    expect_bit("dbg_halt_cmd", cmd_at_wr, 1'b1);
    while (!dbg_halt_cmd && n < LIMIT) begin
      n++;
      tick;
    end
    if (!dbg_halt_cmd) note_timeout("halt command did not return after the step");
    expect_eq("step low cycles", n[15:0], 16'd2);
    wait_halt_st(1'b1);
    report_test("single step", e0);
  endtask

  task halted_mem_access;
    int          e0;
    logic [15:0] w;
    logic [7:0]  b;
    e0 = errors;
    w  = 16'($urandom);
    b  = 8'($urandom);
    // Word write
    reg_write(REG_MEM_ADDR, 16'h0040);
    reg_write(REG_MEM_DATA, w);
    reg_write(REG_MEM_CTL, 16'h0003);
    wait_access;
    expect_eq("mem.addr", acc_addr, 16'h0040);
    expect_eq("mem.dout", acc_dout, w);
    expect_eq("mem.wr", {14'd0, acc_wr}, 16'h0003);
    tick;
    expect_eq("mem_arr[0x20]", u_cpu_model.mem_arr[8'h20], w);
    // Byte write at an odd address
    reg_write(REG_MEM_ADDR, 16'h0041);
    reg_write(REG_MEM_DATA, {8'h00, b});
    reg_write(REG_MEM_CTL, 16'h000B);
    wait_access;
    expect_eq("mem.addr", acc_addr, 16'h0041);
    expect_eq("mem.wr", {14'd0, acc_wr}, 16'h0002);
    tick;
    expect_eq("mem_arr[0x20]", u_cpu_model.mem_arr[8'h20], {b, w[7:0]});
    // Reads land two cycles after en
    reg_write(REG_MEM_ADDR, 16'h0040);
    reg_write(REG_MEM_CTL, 16'h0001);
    wait_access;
    tick;
    tick;
    read_expect(REG_MEM_DATA, {b, w[7:0]}, "MEM_DATA");
    reg_write(REG_MEM_ADDR, 16'h0041);
    reg_write(REG_MEM_CTL, 16'h0009);
    wait_access;
    tick;
    tick;
    read_expect(REG_MEM_DATA, {8'h00, b}, "MEM_DATA");  // High byte zero-extended
    report_test("memory access while halted", e0);
  endtask

  task reg_access_auto_halt;
    int          e0;
    logic [15:0] r;
    e0 = errors;
    r  = 16'($urandom);
    reg_write(REG_CPU_CTL, 16'h0012);  // CPU running
    wait_halt_st(1'b0);
    reg_write(REG_MEM_ADDR, 16'h0005);
    reg_write(REG_MEM_DATA, r);
    reg_write(REG_MEM_CTL, 16'h0007);  // Register write
    expect_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
    wait_access;
    expect_bit("dbg_reg_wr", acc_reg_wr, 1'b1);
    expect_eq("mem.addr", acc_addr, 16'h0005);
    expect_eq("mem.dout", acc_dout, r);
    wait_halt_st(1'b0);                // Resumed
    expect_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    expect_eq("regs[5]", u_cpu_model.regs[5], r);
    // Register read back through MEM_DATA
    reg_write(REG_MEM_DATA, 16'h0000);
    reg_write(REG_MEM_CTL, 16'h0005);
    wait_halt_st(1'b1);
    wait_halt_st(1'b0);
    read_expect(REG_MEM_DATA, r, "MEM_DATA");
    report_test("register access with auto halt", e0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    dbg_clk      = 1'b0;
    dbg_rst      = 1'b1;
    host         = '0;
    cpu_id       = CPU_ID;
    cpu_nr_inst  = NR_INST;
    cpu_nr_total = NR_TOTAL;
    dbg_en_s     = 1'b0;
    cpu_en_s     = 1'b1;
    puc_pnd_set  = 1'b0;
    decode_noirq = 1'b0;
    fe_mdb_in    = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(74));
    repeat (10) @(posedge dbg_clk);
    #2;
    dbg_rst = 1'b0;
    check_reset_state;
    halt_and_run;
    break_sources;
    single_step;
    halted_mem_access;
    reg_access_auto_halt;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
